/* design/l2_array.sv */
`timescale 1ns/1ns

module l2_array
    import l2_geom_pkg::*;
#(
    parameter int width = 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  logic [L2_INDEX_W-1:0] rindex,
    input  logic [L2_INDEX_W-1:0] windex,
    input  logic [width-1:0]      datain,
    output logic [width-1:0]      dataout
);

    logic [width-1:0] entry [L2_SETS];

    // Clocked write, every set cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < L2_SETS; i++) begin
                entry[i] <= '0;
            end
        end else if (load) begin
            entry[windex] <= datain;
        end
    end

    assign dataout = entry[rindex];   // Combinational read

endmodule : l2_array

/* design/l2_cache.sv */
`timescale 1ns/1ns

module l2_cache
    import l2_geom_pkg::*, l2_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    // L1 side
    input  logic [L2_ADDR_W-1:0] mem_address,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  logic [L2_LINE_W-1:0] mem_wdata256,
    output logic [L2_LINE_W-1:0] mem_rdata256,
    output logic                 mem_resp,
    // Memory side
    output logic [L2_ADDR_W-1:0] pmem_address,
    output logic                 pmem_read,
    output logic                 pmem_write,
    output logic [L2_LINE_W-1:0] pmem_wdata256,
    input  logic [L2_LINE_W-1:0] pmem_rdata256,
    input  logic                 pmem_resp
);

    l2_wstat_e wstat;
    logic      load_tag;
    logic      load_valid;
    logic      set_dirty;
    logic      clear_dirty;
    logic      load_lru;
    logic      hit;
    logic      victim_dirty;

    l2_control control (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .pmem_resp    (pmem_resp),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .wstat        (wstat),
        .load_tag     (load_tag),
        .load_valid   (load_valid),
        .set_dirty    (set_dirty),
        .clear_dirty  (clear_dirty),
        .load_lru     (load_lru)
    );

    l2_datapath datapath (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_address   (mem_address),
        .mem_wdata256  (mem_wdata256),
        .pmem_rdata256 (pmem_rdata256),
        .wstat         (wstat),
        .load_tag      (load_tag),
        .load_valid    (load_valid),
        .set_dirty     (set_dirty),
        .clear_dirty   (clear_dirty),
        .load_lru      (load_lru),
        .hit           (hit),
        .victim_dirty  (victim_dirty),
        .mem_rdata256  (mem_rdata256),
        .pmem_address  (pmem_address),
        .pmem_wdata256 (pmem_wdata256)
    );

endmodule : l2_cache

/* design/l2_control.sv */
`timescale 1ns/1ns

module l2_control
    import l2_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      mem_read,
    input  logic      mem_write,
    input  logic      hit,
    input  logic      victim_dirty,
    input  logic      pmem_resp,
    output logic      mem_resp,
    output logic      pmem_read,
    output logic      pmem_write,
    output l2_wstat_e wstat,
    output logic      load_tag,
    output logic      load_valid,
    output logic      set_dirty,
    output logic      clear_dirty,
    output logic      load_lru
);

    l2_state_e state_q;
    l2_state_e state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (mem_read || mem_write) state_d = ST_COMPARE;
            end
            ST_COMPARE: begin
                if (hit) begin
                    state_d = ST_IDLE;
                end else if (victim_dirty) begin
                    state_d = ST_WRITEBACK;
                end else begin
                    state_d = ST_FETCH;
                end
            end
            ST_WRITEBACK: begin
                if (pmem_resp) state_d = ST_FETCH;
            end
            ST_FETCH: begin
                // Filled line hits on the retry
                if (pmem_resp) state_d = ST_COMPARE;
            end
        endcase
    end

    // Outputs decoded from state and inputs
    always_comb begin
        mem_resp    = 1'b0;
        pmem_read   = 1'b0;
        pmem_write  = 1'b0;
        wstat       = WS_NONE;
        load_tag    = 1'b0;
        load_valid  = 1'b0;
        set_dirty   = 1'b0;
        clear_dirty = 1'b0;
        load_lru    = 1'b0;

        unique case (state_q)
            ST_IDLE: ;
            ST_COMPARE: begin
                if (hit) begin
                    mem_resp = 1'b1;
                    load_lru = 1'b1;
                    if (mem_write) begin
                        wstat     = WS_CPU_WRITE;
                        set_dirty = 1'b1;
                    end
                end
            end
            ST_WRITEBACK: begin
                pmem_write = 1'b1;
                wstat      = WS_WRITEBACK;
            end
            ST_FETCH: begin
                pmem_read = 1'b1;
                wstat     = WS_FETCH;
                if (pmem_resp) begin
                    wstat       = WS_FILL;     // Line lands in victim way
                    load_tag    = 1'b1;
                    load_valid  = 1'b1;
                    clear_dirty = 1'b1;
                end
            end
        endcase
    end

    // Memory sees one transfer direction at a time
    a_pmem_excl : assert property (@(posedge clk) disable iff (!rst_n)
        !(pmem_read && pmem_write))
        else $error("l2_control: pmem_read and pmem_write both high");

    // L1 drops its strobe after one response pulse
    a_resp_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp |=> !mem_resp)
        else $error("l2_control: mem_resp high on consecutive cycles");

endmodule : l2_control

/* design/l2_ctrl_pkg.sv */
package l2_ctrl_pkg;

    // Controller sequencing
    typedef enum logic [1:0] {
        ST_IDLE,                // Wait for an L1 strobe
        ST_COMPARE,             // Tag check, respond on hit
        ST_WRITEBACK,           // Flush dirty victim
        ST_FETCH                // Bring in requested line
    } l2_state_e;

    // Datapath write status
    // Bit 0 marks a memory transfer, bit 1 selects the request address,
    // bit 2 means the data array is written this cycle
    typedef enum logic [2:0] {
        WS_NONE      = 3'b000,
        WS_WRITEBACK = 3'b001,  // Victim line and victim address to memory
        WS_FETCH     = 3'b011,  // Request line address to memory
        WS_FILL      = 3'b111,  // Fetch plus load of memory data into victim
        WS_CPU_WRITE = 3'b100   // L1 data into the hit way
    } l2_wstat_e;

endpackage : l2_ctrl_pkg

/* design/l2_datapath.sv */
`timescale 1ns/1ns

module l2_datapath
    import l2_geom_pkg::*, l2_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [L2_ADDR_W-1:0] mem_address,
    input  logic [L2_LINE_W-1:0] mem_wdata256,
    input  logic [L2_LINE_W-1:0] pmem_rdata256,
    input  l2_wstat_e            wstat,
    input  logic                 load_tag,
    input  logic                 load_valid,
    input  logic                 set_dirty,
    input  logic                 clear_dirty,
    input  logic                 load_lru,
    output logic                 hit,
    output logic                 victim_dirty,
    output logic [L2_LINE_W-1:0] mem_rdata256,
    output logic [L2_ADDR_W-1:0] pmem_address,
    output logic [L2_LINE_W-1:0] pmem_wdata256
);

    logic [L2_INDEX_W-1:0] set_idx;
    logic [L2_TAG_W-1:0]   req_tag;

    logic [L2_WAYS-1:0]                valid_out;
    logic [L2_WAYS-1:0]                dirty_out;
    logic [L2_WAYS-1:0][L2_TAG_W-1:0]  tag_out;
    logic [L2_WAYS-1:0][L2_LINE_W-1:0] data_out;

    logic [L2_WAYS-1:0] valid_ld;
    logic [L2_WAYS-1:0] dirty_ld;
    logic [L2_WAYS-1:0] tag_ld;
    logic [L2_WAYS-1:0] data_ld;
    logic [L2_LINE_W-1:0] data_in;

    logic [L2_WAYS-1:0]   match;
    logic [L2_WAY_W-1:0]  hit_way;
    logic [L2_WAY_W-1:0]  victim_way;
    logic [L2_PLRU_W-1:0] lru_state;
    logic [L2_PLRU_W-1:0] lru_next;

    assign set_idx = mem_address[L2_OFFSET_W +: L2_INDEX_W];
    assign req_tag = mem_address[L2_ADDR_W-1 -: L2_TAG_W];

    // One set of field arrays per way
    for (genvar w = 0; w < L2_WAYS; w++) begin : g_way
        l2_array #(.width(1)) valid_arr (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    (valid_ld[w]),
            .rindex  (set_idx),
            .windex  (set_idx),
            .datain  (1'b1),
            .dataout (valid_out[w])
        );

        l2_array #(.width(1)) dirty_arr (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    (dirty_ld[w]),
            .rindex  (set_idx),
            .windex  (set_idx),
            .datain  (set_dirty),      // 1 on write hit, 0 on fill
            .dataout (dirty_out[w])
        );

        l2_array #(.width(L2_TAG_W)) tag_arr (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    (tag_ld[w]),
            .rindex  (set_idx),
            .windex  (set_idx),
            .datain  (req_tag),
            .dataout (tag_out[w])
        );

        l2_array #(.width(L2_LINE_W)) data_arr (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    (data_ld[w]),
            .rindex  (set_idx),
            .windex  (set_idx),
            .datain  (data_in),
            .dataout (data_out[w])
        );

        assign match[w] = valid_out[w] && (tag_out[w] == req_tag);
    end

    l2_array #(.width(L2_PLRU_W)) lru_arr (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load_lru),
        .rindex  (set_idx),
        .windex  (set_idx),
        .datain  (lru_next),
        .dataout (lru_state)
    );

    l2_plru plru (
        .state      (lru_state),
        .access_way (hit_way),
        .victim_way (victim_way),
        .next_state (lru_next)
    );

    // Hit way encode
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < L2_WAYS; w++) begin
            if (match[w]) hit_way = L2_WAY_W'(w);
        end
    end

    assign hit          = |match;
    assign victim_dirty = valid_out[victim_way] && dirty_out[victim_way];

    // Write enables, hit way for L1 side updates, victim way for refills
    always_comb begin
        for (int w = 0; w < L2_WAYS; w++) begin
            valid_ld[w] = load_valid && (victim_way == L2_WAY_W'(w));
            tag_ld[w]   = load_tag && (victim_way == L2_WAY_W'(w));
            dirty_ld[w] = (set_dirty && hit && (hit_way == L2_WAY_W'(w)))
                       || (clear_dirty && (victim_way == L2_WAY_W'(w)));
            data_ld[w]  = ((wstat == WS_CPU_WRITE) && hit && (hit_way == L2_WAY_W'(w)))
                       || ((wstat == WS_FILL) && (victim_way == L2_WAY_W'(w)));
        end
    end

    assign data_in = (wstat == WS_FILL) ? pmem_rdata256 : mem_wdata256;

    assign mem_rdata256  = data_out[hit_way];
    assign pmem_wdata256 = data_out[victim_way];   // Only sampled during write-back

    always_comb begin
        unique case (wstat)
            WS_WRITEBACK:
                pmem_address = {tag_out[victim_way], set_idx, {L2_OFFSET_W{1'b0}}};
            WS_FETCH, WS_FILL:
                pmem_address = {mem_address[L2_ADDR_W-1:L2_OFFSET_W], {L2_OFFSET_W{1'b0}}};
            default:
                pmem_address = '0;
        endcase
    end

    // Duplicate tags in a set would mean a fill skipped the victim way
    a_match_onehot0 : assert property (@(posedge clk) disable iff (!rst_n) $onehot0(match))
        else $error("l2_datapath: tag %h matches more than one way in set %0d",
                    req_tag, set_idx);

endmodule : l2_datapath

/* design/l2_geom_pkg.sv */
package l2_geom_pkg;

    // Address split is tag | index | offset
    localparam int L2_ADDR_W   = 32;
    localparam int L2_OFFSET_W = 5;     // Byte offset within a 32-byte line
    localparam int L2_INDEX_W  = 3;     // Set select
    localparam int L2_TAG_W    = L2_ADDR_W - L2_INDEX_W - L2_OFFSET_W;

    // Organization
    localparam int L2_SETS  = 2 ** L2_INDEX_W;
    localparam int L2_WAYS  = 4;
    localparam int L2_WAY_W = 2;        // Bits to name one way

    // Line payload, one full line per transfer on both sides
    localparam int L2_LINE_W = 8 * (2 ** L2_OFFSET_W);

    // Tree pseudo-LRU, one bit per internal node of a 4-leaf tree
    localparam int L2_PLRU_W = L2_WAYS - 1;

endpackage : l2_geom_pkg

/* design/l2_plru.sv */
`timescale 1ns/1ns

module l2_plru
    import l2_geom_pkg::*;
(
    input  logic [L2_PLRU_W-1:0] state,
    input  logic [L2_WAY_W-1:0]  access_way,
    output logic [L2_WAY_W-1:0]  victim_way,
    output logic [L2_PLRU_W-1:0] next_state
);

    // Bit 2 is the root, bit 0 guards ways 0/1, bit 1 guards ways 2/3
    always_comb begin
        if (state[2]) begin
            victim_way = state[1] ? 2'd3 : 2'd2;
        end else begin
            victim_way = state[0] ? 2'd1 : 2'd0;
        end
    end

    // Point the tree away from the way just used
    always_comb begin
        next_state = state;
        unique case (access_way)
            2'd0: begin
                next_state[2] = 1'b1;
                next_state[0] = 1'b1;
            end
            2'd1: begin
                next_state[2] = 1'b1;
                next_state[0] = 1'b0;
            end
            2'd2: begin
                next_state[2] = 1'b0;
                next_state[1] = 1'b1;
            end
            2'd3: begin
                next_state[2] = 1'b0;
                next_state[1] = 1'b0;
            end
        endcase
    end

endmodule : l2_plru

/* project.f */
design/l2_geom_pkg.sv
design/l2_ctrl_pkg.sv
design/l2_array.sv
design/l2_plru.sv
design/l2_datapath.sv
design/l2_control.sv
design/l2_cache.sv
verif/l2_mem_model.sv
verif/l2_cache_tb.sv

/* verif/l2_cache_tb.sv */
`timescale 1ns/1ns

module l2_cache_tb
    import l2_geom_pkg::*;
;

    localparam int TOTAL_REQUESTS = 2000;
    localparam int RESP_TIMEOUT   = 200;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic [L2_ADDR_W-1:0] mem_address;
    logic                 mem_read;
    logic                 mem_write;
    logic [L2_LINE_W-1:0] mem_wdata256;
    logic [L2_LINE_W-1:0] mem_rdata256;
    logic                 mem_resp;
    logic [L2_ADDR_W-1:0] pmem_address;
    logic                 pmem_read;
    logic                 pmem_write;
    logic [L2_LINE_W-1:0] pmem_wdata256;
    logic [L2_LINE_W-1:0] pmem_rdata256;
    logic                 pmem_resp;
    int                   wb_count;
    int                   rd_count;
    logic [L2_ADDR_W-1:0] wb_address;
    logic [L2_LINE_W-1:0] wb_data;
    logic [L2_ADDR_W-1:0] rd_address;

    logic [31:0] lfsr = 32'heb63e189;
    int          done_count = 0;

    // Small tag pool so that sets overflow and lines come back
    logic [L2_TAG_W-1:0] tag_pool [6] = '{24'h000001, 24'h00a5c3, 24'h123456,
                                         24'hfedcba, 24'h800000, 24'h3c3c3c};

    // Reference cache state
    logic [L2_TAG_W-1:0]  m_tag   [L2_SETS][L2_WAYS] = '{default: '0};
    logic                 m_valid [L2_SETS][L2_WAYS] = '{default: '0};
    logic                 m_dirty [L2_SETS][L2_WAYS] = '{default: '0};
    logic [L2_PLRU_W-1:0] m_plru  [L2_SETS] = '{default: '0};
    logic [L2_LINE_W-1:0] golden  [logic [L2_ADDR_W-1:0]];

    always #2 clk = ~clk;

    l2_cache dut (.*);

    l2_mem_model mem (.*);

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return val;
    endfunction

    function automatic logic [L2_LINE_W-1:0] random_line();
        logic [L2_LINE_W-1:0] v;
        for (int i = 0; i < L2_LINE_W / 32; i++) v[32*i +: 32] = take_bits(32);
        return v;
    endfunction

    function automatic logic [L2_LINE_W-1:0] fill_pattern(input logic [L2_ADDR_W-1:0] a);
        logic [L2_LINE_W-1:0] pat;
        for (int i = 0; i < L2_LINE_W / 32; i++) begin
            pat[32*i +: 32] = (a ^ 32'h5a0f_c3e1) + 32'h0101_0101 * i;
        end
        return pat;
    endfunction

    function automatic logic [L2_LINE_W-1:0] line_of(input logic [L2_ADDR_W-1:0] a);
        return golden.exists(a) ? golden[a] : fill_pattern(a);
    endfunction

    // Root bit picks the half, the child bit picks the way within it
    function automatic int plru_victim(input logic [2:0] s);
        if (s[2]) return s[1] ? 3 : 2;
        return s[0] ? 1 : 0;
    endfunction

    function automatic logic [2:0] plru_touch(input logic [2:0] s, input int way);
        if (way < 2) return {1'b1, s[1], way == 0};
        return {1'b0, way == 2, s[0]};
    endfunction

    task automatic report_mismatch(input string name, input logic [L2_LINE_W-1:0] got,
                                   input logic [L2_LINE_W-1:0] exp);
        $display("MISMATCH %s: got %0h expected %0h", name, got, exp);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic run_request(input logic wr, input logic [L2_TAG_W-1:0] tag,
                               input logic [L2_INDEX_W-1:0] set,
                               input logic [L2_LINE_W-1:0] data);
        logic [L2_ADDR_W-1:0] addr;
        logic [L2_ADDR_W-1:0] wb_addr;
        logic [L2_LINE_W-1:0] wb_line;
        int way;
        int wb_before;
        int rd_before;
        int cycles;
        bit expect_wb;
        bit expect_fill;
        bit strobe_seen;
        addr = {tag, set, {L2_OFFSET_W{1'b0}}};
        way  = -1;
        for (int w = 0; w < L2_WAYS; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) way = w;
        end
        expect_fill = (way < 0);
        expect_wb   = 1'b0;
        if (expect_fill) begin
            way       = plru_victim(m_plru[set]);
            expect_wb = m_valid[set][way] && m_dirty[set][way];
            wb_addr   = {m_tag[set][way], set, {L2_OFFSET_W{1'b0}}};
            wb_line   = line_of(wb_addr);
            m_tag[set][way]   = tag;
            m_valid[set][way] = 1'b1;
            m_dirty[set][way] = 1'b0;
        end
        m_plru[set] = plru_touch(m_plru[set], way);
        wb_before = wb_count;
        rd_before = rd_count;

        @(posedge clk);
        mem_address  <= addr;
        mem_read     <= !wr;
        mem_write    <= wr;
        mem_wdata256 <= data;
        cycles      = 0;
        strobe_seen = 1'b0;
        do begin
            @(posedge clk);
            cycles++;
            if (pmem_read || pmem_write) strobe_seen = 1'b1;
        end while (!mem_resp && cycles < RESP_TIMEOUT);
        assert (mem_resp) else report_failure("Timed out waiting for mem_resp from the cache");
        mem_read  <= 1'b0;
        mem_write <= 1'b0;

        // A hit answers one cycle after the request is sampled, with no memory traffic
        if (!expect_fill) begin
            assert (cycles == 2)
                else report_failure("Hit did not respond one cycle after the request was sampled");
            assert (!strobe_seen) else report_failure("Memory strobe raised during a cache hit");
        end

        if (wr) begin
            golden[addr]      = data;
            m_dirty[set][way] = 1'b1;
        end else begin
            assert (mem_rdata256 == line_of(addr))
                else report_mismatch("mem_rdata256", mem_rdata256, line_of(addr));
        end
        assert (wb_count - wb_before == int'(expect_wb))
            else report_mismatch("write-back count", wb_count - wb_before, expect_wb);
        assert (rd_count - rd_before == int'(expect_fill))
            else report_mismatch("fetch count", rd_count - rd_before, expect_fill);
        if (expect_wb) begin
            assert (wb_address == wb_addr)
                else report_mismatch("pmem_address (write-back)", wb_address, wb_addr);
            assert (wb_data == wb_line) else report_mismatch("pmem_wdata256", wb_data, wb_line);
        end
        if (expect_fill) begin
            assert (rd_address == addr)
                else report_mismatch("pmem_address (fetch)", rd_address, addr);
        end
        done_count++;
    endtask

    initial begin
        logic                  wr;
        logic [L2_TAG_W-1:0]   tag;
        logic [L2_INDEX_W-1:0] set;
        rst_n        = 1'b0;
        mem_address  = '0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        mem_wdata256 = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!mem_resp && !pmem_read && !pmem_write)
            else report_failure("A response or memory strobe is high after reset");

        // Directed: four dirty ways in set 3, known access order, then evict
        for (int i = 0; i < L2_WAYS; i++) run_request(1'b1, tag_pool[i], 3'd3, random_line());
        run_request(1'b0, tag_pool[2], 3'd3, '0);
        run_request(1'b0, tag_pool[0], 3'd3, '0);
        run_request(1'b0, tag_pool[3], 3'd3, '0);
        run_request(1'b0, tag_pool[1], 3'd3, '0);
        run_request(1'b1, tag_pool[4], 3'd3, random_line());

        while (done_count < TOTAL_REQUESTS) begin
            wr  = take_bits(1);
            tag = tag_pool[take_bits(3) % 6];
            set = take_bits(L2_INDEX_W);
            run_request(wr, tag, set, wr ? random_line() : '0);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule : l2_cache_tb

/* verif/l2_mem_model.sv */
`timescale 1ns/1ns

module l2_mem_model
    import l2_geom_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [L2_ADDR_W-1:0] pmem_address,
    input  logic                 pmem_read,
    input  logic                 pmem_write,
    input  logic [L2_LINE_W-1:0] pmem_wdata256,
    output logic [L2_LINE_W-1:0] pmem_rdata256,
    output logic                 pmem_resp,
    output int                   wb_count,     // Completed write-backs
    output int                   rd_count,     // Completed fetches
    output logic [L2_ADDR_W-1:0] wb_address,   // Last write-back seen
    output logic [L2_LINE_W-1:0] wb_data,
    output logic [L2_ADDR_W-1:0] rd_address    // Last fetch seen
);

    logic [31:0] lfsr = 32'heb63e189;
    logic [L2_LINE_W-1:0] store [logic [L2_ADDR_W-1:0]];
    int wait_left;

    // Lines never written back read as a pattern of their own address
    function automatic logic [L2_LINE_W-1:0] fill_pattern(input logic [L2_ADDR_W-1:0] a);
        logic [L2_LINE_W-1:0] pat;
        for (int i = 0; i < L2_LINE_W / 32; i++) begin
            pat[32*i +: 32] = (a ^ 32'h5a0f_c3e1) + 32'h0101_0101 * i;
        end
        return pat;
    endfunction

    // Galois LFSR, three bits per draw, 1 to 6 cycles
    function automatic int pick_latency();
        logic [2:0] v;
        v = '0;
        for (int i = 0; i < 3; i++) begin
            v    = {v[1:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return 1 + (v % 6);
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pmem_resp     <= 1'b0;
            pmem_rdata256 <= '0;
            wait_left     <= 0;
            wb_count      <= 0;
            rd_count      <= 0;
            wb_address    <= '0;
            wb_data       <= '0;
            rd_address    <= '0;
        end else if (pmem_resp) begin
            pmem_resp <= 1'b0;           // One-cycle pulse, strobe seen anew next edge
        end else if (pmem_read || pmem_write) begin
            if (wait_left == 0) begin
                wait_left <= pick_latency();
            end else if (wait_left > 1) begin
                wait_left <= wait_left - 1;
            end else begin
                wait_left <= 0;
                pmem_resp <= 1'b1;
                if (pmem_write) begin
                    store[pmem_address] = pmem_wdata256;
                    wb_count   <= wb_count + 1;
                    wb_address <= pmem_address;
                    wb_data    <= pmem_wdata256;
                end else begin
                    pmem_rdata256 <= store.exists(pmem_address) ? store[pmem_address]
                                                                : fill_pattern(pmem_address);
                    rd_count   <= rd_count + 1;
                    rd_address <= pmem_address;
                end
            end
        end
    end

endmodule : l2_mem_model
